//--- design/fixed_pkg.sv
package fixed_pkg;

    // Q16.16 signed format used on every datapath
    localparam int FRACTIONAL_BITS = 16;

    typedef logic signed [31:0] fixed;

    // Real to fixed with rounding to nearest, for constants only
    function automatic fixed rtof(input real value);
        real scaled;
        scaled = value * real'(1 << FRACTIONAL_BITS);
        return fixed'($rtoi((scaled < 0.0) ? scaled - 0.5 : scaled + 0.5));
    endfunction

    // Full product, then drop the extra fraction bits
    function automatic fixed mul(input fixed a, input fixed b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] product;
        logic signed [63:0] shifted;
        wide_a  = a;
        wide_b  = b;
        product = wide_a * wide_b;
        shifted = product >>> FRACTIONAL_BITS;
        return shifted[31:0];
    endfunction

    // Limit value to the closed range lo..hi
    function automatic fixed clamp(input fixed value, input fixed lo, input fixed hi);
        fixed result;
        if (value < lo) begin
            result = lo;
        end else if (value > hi) begin
            result = hi;
        end else begin
            result = value;
        end
        return result;
    endfunction

endpackage

//--- design/geometry_pkg.sv
package geometry_pkg;
    import fixed_pkg::*;

    // RGB565
    typedef logic [15:0] color_t;

    typedef struct packed {
        fixed x;
        fixed y;
        fixed z;
    } position_t;

    typedef struct packed {
        position_t position;
        color_t    color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic [15:0] id;
        // Last triangle of the current object
        logic        last;
    } triangle_meta_t;

    localparam int  VIEWPORT_WIDTH  = 160;
    localparam int  VIEWPORT_HEIGHT = 120;
    localparam real FOCAL_LENGTH    = 0.1;
    localparam real ASPECT_RATIO    = real'(VIEWPORT_WIDTH) / real'(VIEWPORT_HEIGHT);

    localparam fixed FOCAL_X  = rtof(FOCAL_LENGTH * real'(VIEWPORT_WIDTH));
    localparam fixed FOCAL_Y  = rtof(FOCAL_LENGTH * real'(VIEWPORT_HEIGHT) * ASPECT_RATIO);
    localparam fixed CENTER_X = rtof(real'(VIEWPORT_WIDTH) / 2.0);
    localparam fixed CENTER_Y = rtof(real'(VIEWPORT_HEIGHT) / 2.0);

    // First coordinate past the right and bottom edges
    localparam fixed VIEWPORT_X_END = rtof(real'(VIEWPORT_WIDTH));
    localparam fixed VIEWPORT_Y_END = rtof(real'(VIEWPORT_HEIGHT));

    localparam fixed Z_NEAR = rtof(1.0);
    localparam fixed Z_FAR  = rtof(1000.0);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_DIV,
        S_WAIT_DIV,
        S_PROJ,
        S_OUT
    } proj_state_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

//--- design/triangle_stream_if.sv
interface triangle_stream_if;
    import geometry_pkg::*;

    triangle_t      data;
    triangle_meta_t meta;
    logic           valid;
    logic           ready;

    modport source (
        output data,
        output meta,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  meta,
        input  valid,
        output ready
    );

endinterface

//--- design/triangle_intake.sv
module triangle_intake (
    input  logic                         clk,
    input  logic                         rstn,
    input  geometry_pkg::triangle_t      in_data,
    input  geometry_pkg::triangle_meta_t in_meta,
    input  logic                         in_valid,
    output logic                         in_ready,
    triangle_stream_if.source            tri_out
);
    import geometry_pkg::*;

    triangle_t      entry_data;
    triangle_meta_t entry_meta;
    logic           full;
    logic           accept;

    // Room when empty or when the entry leaves this cycle
    assign in_ready = !full || tri_out.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (tri_out.ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entry_data <= in_data;
            entry_meta <= in_meta;
        end
    end

    assign tri_out.valid = full;
    assign tri_out.data  = entry_data;
    assign tri_out.meta  = entry_meta;

endmodule

//--- design/reciprocal_divider.sv
module reciprocal_divider (
    input  logic            clk,
    input  logic            rstn,
    input  fixed_pkg::fixed divisor_data,
    input  logic            divisor_valid,
    output logic            divisor_ready,
    output fixed_pkg::fixed result_data,
    output logic            result_valid,
    input  logic            result_ready
);
    import fixed_pkg::*;
    import geometry_pkg::*;

    div_state_t  state;
    logic [5:0]  step;
    fixed        z_raw;
    logic [31:0] divisor;
    logic [31:0] remainder;
    logic [31:0] quotient;
    logic [32:0] shifted;
    logic        fits;

    // One restoring step per quotient bit
    assign shifted = {remainder, 1'b0};
    assign fits    = shifted >= {1'b0, divisor};

    assign divisor_ready = (state == DIV_IDLE);
    assign result_valid  = (state == DIV_DONE);
    assign result_data   = fixed'(quotient);

    // Step 0 seeds, steps 1 to 32 each produce one quotient bit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (divisor_valid) begin
                        state <= DIV_RUN;
                        step  <= '0;
                    end
                end
                DIV_RUN: begin
                    if (step == 6'(2 * FRACTIONAL_BITS)) begin
                        state <= DIV_DONE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                DIV_DONE: begin
                    if (result_ready) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && divisor_valid) begin
            z_raw <= divisor_data;
        end else if (state == DIV_RUN) begin
            if (step == '0) begin
                // Clamp is registered here, off the subtractor path
                divisor   <= clamp(z_raw, Z_NEAR, Z_FAR);
                // Top dividend bit of 2^32 is already shifted in
                remainder <= 32'd1;
                quotient  <= '0;
            end else begin
                quotient  <= {quotient[30:0], fits};
                remainder <= fits ? 32'(shifted - {1'b0, divisor}) : shifted[31:0];
            end
        end
    end

endmodule

//--- design/triangle_projection.sv
module triangle_projection (
    input  logic              clk,
    input  logic              rstn,
    triangle_stream_if.sink   tri_in,
    triangle_stream_if.source tri_out
);
    import fixed_pkg::*;
    import geometry_pkg::*;

    proj_state_t    state;
    proj_state_t    next_state;
    logic [1:0]     vtx_idx;
    triangle_t      tri_q;
    triangle_meta_t meta_q;
    triangle_t      proj_q;
    fixed           rec_z [3];
    fixed           current_z;

    logic           div_in_valid;
    logic           div_in_ready;
    fixed           div_result;
    logic           div_out_valid;
    logic           div_out_ready;
    logic           accept;
    logic           rec_done;

    // Screen position from focal length, 1/z and viewport center
    function automatic vertex_t project_vertex(input vertex_t v, input fixed rec);
        vertex_t p;
        p.position.x = mul(mul(FOCAL_X, rec), v.position.x) + CENTER_X;
        p.position.y = mul(mul(FOCAL_Y, rec), v.position.y) + CENTER_Y;
        p.position.z = rec;
        p.color      = v.color;
        return p;
    endfunction

    reciprocal_divider reciprocal_divider_i (
        .clk           (clk),
        .rstn          (rstn),
        .divisor_data  (current_z),
        .divisor_valid (div_in_valid),
        .divisor_ready (div_in_ready),
        .result_data   (div_result),
        .result_valid  (div_out_valid),
        .result_ready  (div_out_ready)
    );

    assign tri_in.ready  = (state == S_IDLE);
    assign accept        = tri_in.valid && tri_in.ready;
    assign div_in_valid  = (state == S_LOAD_DIV);
    assign div_out_ready = (state == S_WAIT_DIV);
    assign rec_done      = div_out_valid && div_out_ready;

    // Divider input follows the vertex index
    always_comb begin
        case (vtx_idx)
            2'd0:    current_z = tri_q.v0.position.z;
            2'd1:    current_z = tri_q.v1.position.z;
            default: current_z = tri_q.v2.position.z;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (tri_in.valid) begin
                    next_state = S_LOAD_DIV;
                end
            end
            S_LOAD_DIV: begin
                if (div_in_ready) begin
                    next_state = S_WAIT_DIV;
                end
            end
            S_WAIT_DIV: begin
                if (div_out_valid) begin
                    next_state = (vtx_idx == 2'd2) ? S_PROJ : S_LOAD_DIV;
                end
            end
            S_PROJ: next_state = S_OUT;
            S_OUT: begin
                if (tri_out.ready) begin
                    next_state = S_IDLE;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= S_IDLE;
            vtx_idx <= '0;
        end else begin
            state <= next_state;
            if (accept) begin
                vtx_idx <= '0;
            end else if (rec_done && vtx_idx != 2'd2) begin
                vtx_idx <= vtx_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tri_q  <= tri_in.data;
            meta_q <= tri_in.meta;
        end
        if (rec_done) begin
            rec_z[vtx_idx] <= div_result;
        end
        if (state == S_PROJ) begin
            proj_q.v0 <= project_vertex(tri_q.v0, rec_z[0]);
            proj_q.v1 <= project_vertex(tri_q.v1, rec_z[1]);
            proj_q.v2 <= project_vertex(tri_q.v2, rec_z[2]);
        end
    end

    assign tri_out.valid = (state == S_OUT);
    assign tri_out.data  = proj_q;
    assign tri_out.meta  = meta_q;

endmodule

//--- design/viewport_cull.sv
module viewport_cull (
    input  logic                         clk,
    input  logic                         rstn,
    triangle_stream_if.sink              tri_in,
    output geometry_pkg::triangle_t      out_data,
    output geometry_pkg::triangle_meta_t out_meta,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [15:0]                  culled_count
);
    import geometry_pkg::*;

    logic accept;
    logic drop;

    // Whole triangle beyond one viewport edge
    function automatic logic off_screen(input triangle_t t);
        logic left;
        logic right;
        logic above;
        logic below;
        left  = (t.v0.position.x < 0) && (t.v1.position.x < 0) && (t.v2.position.x < 0);
        right = (t.v0.position.x >= VIEWPORT_X_END) && (t.v1.position.x >= VIEWPORT_X_END)
             && (t.v2.position.x >= VIEWPORT_X_END);
        above = (t.v0.position.y < 0) && (t.v1.position.y < 0) && (t.v2.position.y < 0);
        below = (t.v0.position.y >= VIEWPORT_Y_END) && (t.v1.position.y >= VIEWPORT_Y_END)
             && (t.v2.position.y >= VIEWPORT_Y_END);
        return left || right || above || below;
    endfunction

    assign tri_in.ready = !out_valid || out_ready;
    assign accept       = tri_in.valid && tri_in.ready;
    assign drop         = off_screen(tri_in.data);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid    <= 1'b0;
            culled_count <= '0;
        end else begin
            if (accept) begin
                out_valid <= !drop;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // Wraps at 16 bits
            if (accept && drop) begin
                culled_count <= culled_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !drop) begin
            out_data <= tri_in.data;
            out_meta <= tri_in.meta;
        end
    end

endmodule

//--- design/raster_front_top.sv
module raster_front_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  geometry_pkg::triangle_t      in_data,
    input  geometry_pkg::triangle_meta_t in_meta,
    input  logic                         in_valid,
    output logic                         in_ready,
    output geometry_pkg::triangle_t      out_data,
    output geometry_pkg::triangle_meta_t out_meta,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [15:0]                  culled_count
);

    triangle_stream_if in_to_proj ();
    triangle_stream_if proj_to_cull ();

    triangle_intake triangle_intake_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_data  (in_data),
        .in_meta  (in_meta),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .tri_out  (in_to_proj.source)
    );

    // Three 1/z divisions per triangle
    triangle_projection triangle_projection_i (
        .clk     (clk),
        .rstn    (rstn),
        .tri_in  (in_to_proj.sink),
        .tri_out (proj_to_cull.source)
    );

    viewport_cull viewport_cull_i (
        .clk          (clk),
        .rstn         (rstn),
        .tri_in       (proj_to_cull.sink),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .culled_count (culled_count)
    );

endmodule

//--- testbench/raster_front_checks.svh
`ifndef RASTER_FRONT_CHECKS_SVH
`define RASTER_FRONT_CHECKS_SVH

// Q16.16 product, low word of the shifted 64-bit result
function automatic fixed fixed_product(input fixed a, input fixed b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] full;
    wide_a = a;
    wide_b = b;
    full   = (wide_a * wide_b) >>> FRACTIONAL_BITS;
    return full[31:0];
endfunction

// 2^32 over the clamped raw z, rounded down
function automatic fixed reciprocal_of(input fixed z);
    fixed        z_clamped;
    logic [63:0] quotient;
    z_clamped = z;
    if (z_clamped < Z_NEAR) begin
        z_clamped = Z_NEAR;
    end
    if (z_clamped > Z_FAR) begin
        z_clamped = Z_FAR;
    end
    quotient = 64'h1_0000_0000 / {32'd0, z_clamped};
    return fixed'(quotient[31:0]);
endfunction

function automatic vertex_t screen_vertex(input vertex_t v);
    vertex_t p;
    fixed    rec;
    rec          = reciprocal_of(v.position.z);
    p.position.x = fixed_product(fixed_product(FOCAL_X, rec), v.position.x) + CENTER_X;
    p.position.y = fixed_product(fixed_product(FOCAL_Y, rec), v.position.y) + CENTER_Y;
    p.position.z = rec;
    p.color      = v.color;
    return p;
endfunction

function automatic triangle_t projected_triangle(input triangle_t t);
    triangle_t p;
    p.v0 = screen_vertex(t.v0);
    p.v1 = screen_vertex(t.v1);
    p.v2 = screen_vertex(t.v2);
    return p;
endfunction

// All three vertices past the same viewport edge
function automatic logic is_off_screen(input triangle_t p);
    fixed x [3];
    fixed y [3];
    fixed x_end;
    fixed y_end;
    x     = '{p.v0.position.x, p.v1.position.x, p.v2.position.x};
    y     = '{p.v0.position.y, p.v1.position.y, p.v2.position.y};
    x_end = VIEWPORT_WIDTH * (1 << FRACTIONAL_BITS);
    y_end = VIEWPORT_HEIGHT * (1 << FRACTIONAL_BITS);
    return (x[0] < 0 && x[1] < 0 && x[2] < 0)
        || (x[0] >= x_end && x[1] >= x_end && x[2] >= x_end)
        || (y[0] < 0 && y[1] < 0 && y[2] < 0)
        || (y[0] >= y_end && y[1] >= y_end && y[2] >= y_end);
endfunction

task automatic check_triangle(input string name, input triangle_t expected,
                              input triangle_t actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic check_meta(input string name, input triangle_meta_t expected,
                          input triangle_meta_t actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic check_count(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        abort_run();
    end
endtask

`endif

//--- testbench/raster_front_tb.sv
module raster_front_tb;
    import fixed_pkg::*;
    import geometry_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int STREAM_LENGTH  = 12;

    logic           clk;
    logic           rstn;
    triangle_t      in_data;
    triangle_meta_t in_meta;
    logic           in_valid;
    logic           in_ready;
    triangle_t      out_data;
    triangle_meta_t out_meta;
    logic           out_valid;
    logic           out_ready;
    logic [15:0]    culled_count;
    integer         seed;

    // Running total of triangles the model expects to be dropped
    logic [15:0]    culled_expected;

    // Surviving triangles still owed by the DUT, oldest first
    triangle_t      pending_tris [$];
    triangle_meta_t pending_metas [$];

    raster_front_top raster_front_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .in_data      (in_data),
        .in_meta      (in_meta),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .culled_count (culled_count)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        abort_run();
    endtask

    `include "raster_front_checks.svh"

    function automatic vertex_t make_vertex(input real x, input real y, input real z,
                                            input color_t color);
        vertex_t v;
        v.position.x = rtof(x);
        v.position.y = rtof(y);
        v.position.z = rtof(z);
        v.color      = color;
        return v;
    endfunction

    // x and y in -16..16, z in 0.5..8.5, pushed right by 100 when asked
    function automatic triangle_t random_triangle(input logic far_right);
        vertex_t v [3];
        int      k;
        for (k = 0; k < 3; k++) begin
            v[k].position.x = fixed'(($random(seed) & 32'h001F_FFFF) - 32'h0010_0000);
            if (far_right) begin
                v[k].position.x = v[k].position.x + rtof(100.0);
            end
            v[k].position.y = fixed'(($random(seed) & 32'h001F_FFFF) - 32'h0010_0000);
            v[k].position.z = fixed'(($random(seed) & 32'h0007_FFFF) + 32'h0000_8000);
            v[k].color      = 16'($random(seed));
        end
        return '{v[0], v[1], v[2]};
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_triangle(input triangle_t t, input triangle_meta_t m);
        int cycles;
        in_data  = t;
        in_meta  = m;
        in_valid = 1'b1;
        cycles   = 0;
        while (!in_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("in_ready");
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic receive_and_check(input triangle_t t, input triangle_meta_t m);
        int cycles;
        cycles = 0;
        while (!out_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("out_valid");
            end
        end
        check_triangle("out_data", t, out_data);
        check_meta("out_meta", m, out_meta);
        @(negedge clk);
    endtask

    task automatic wait_for_count(input logic [15:0] expected);
        int cycles;
        cycles = 0;
        while (culled_count != expected) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("culled_count to reach its expected value");
            end
        end
    endtask

    // Random stalls on out_ready, every output compared with the queue head
    task automatic collect_with_stalls();
        int cycles;
        int stall_left;
        cycles     = 0;
        stall_left = 0;
        while (pending_tris.size() > 0) begin
            @(negedge clk);
            if (stall_left > 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else begin
                out_ready = 1'b1;
                if (($random(seed) & 3) == 0) begin
                    stall_left = ($random(seed) & 7) + 1;
                end
            end
            // Also catches data that moves while stalled
            if (out_valid) begin
                check_triangle("out_data", pending_tris[0], out_data);
                check_meta("out_meta", pending_metas[0], out_meta);
                if (out_ready) begin
                    void'(pending_tris.pop_front());
                    void'(pending_metas.pop_front());
                    cycles = 0;
                end
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout("the next surviving triangle");
            end
        end
        @(negedge clk);
        out_ready = 1'b1;
    endtask

    task automatic test_reset_state();
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
        check_count("culled_count", 16'd0, culled_count);
    endtask

    task automatic test_single_visible();
        triangle_t      t;
        triangle_meta_t m;
        t.v0   = make_vertex(2.0, 1.0, 2.0, 16'hF800);
        t.v1   = make_vertex(-3.0, 2.5, 4.0, 16'h07E0);
        t.v2   = make_vertex(4.0, -6.0, 10.0, 16'h001F);
        m.id   = 16'h0101;
        m.last = 1'b1;
        send_triangle(t, m);
        receive_and_check(projected_triangle(t), m);
    endtask

    task automatic test_z_clamp();
        triangle_t      t;
        triangle_t      clamped;
        triangle_meta_t m;
        t.v0   = make_vertex(1.0, 1.0, 0.25, 16'h1234);
        t.v1   = make_vertex(500.0, -300.0, 5000.0, 16'h5678);
        t.v2   = make_vertex(0.5, 0.5, 2.0, 16'h9ABC);
        m.id   = 16'h0202;
        m.last = 1'b0;
        // Same triangle with z already at the clamp limits
        clamped               = t;
        clamped.v0.position.z = rtof(1.0);
        clamped.v1.position.z = rtof(1000.0);
        send_triangle(t, m);
        receive_and_check(projected_triangle(clamped), m);
    endtask

    task automatic test_right_cull();
        triangle_t      t;
        triangle_meta_t m;
        t.v0   = make_vertex(10.0, 0.0, 1.0, 16'hFFFF);
        t.v1   = make_vertex(12.0, 1.0, 1.0, 16'hFFFF);
        t.v2   = make_vertex(20.0, -1.0, 1.0, 16'hFFFF);
        m.id   = 16'h0303;
        m.last = 1'b0;
        culled_expected = culled_expected + 16'd1;
        send_triangle(t, m);
        wait_for_count(culled_expected);
        check_flag("out_valid", 1'b0, out_valid);
        t.v0.position.x = rtof(1.0);
        m.id            = 16'h0304;
        send_triangle(t, m);
        receive_and_check(projected_triangle(t), m);
        check_count("culled_count", culled_expected, culled_count);
    endtask

    task automatic test_random_stream();
        triangle_t      tris [STREAM_LENGTH];
        triangle_meta_t metas [STREAM_LENGTH];
        int             i;
        for (i = 0; i < STREAM_LENGTH; i++) begin
            tris[i]       = random_triangle(i % 4 == 3);
            metas[i].id   = 16'(i);
            metas[i].last = (i == STREAM_LENGTH - 1);
            if (is_off_screen(projected_triangle(tris[i]))) begin
                culled_expected = culled_expected + 16'd1;
            end else begin
                pending_tris.push_back(projected_triangle(tris[i]));
                pending_metas.push_back(metas[i]);
            end
        end
        fork
            begin
                for (int n = 0; n < STREAM_LENGTH; n++) begin
                    send_triangle(tris[n], metas[n]);
                end
            end
            collect_with_stalls();
        join
        wait_for_count(culled_expected);
        check_flag("out_valid", 1'b0, out_valid);
    endtask

    initial begin
        seed            = 32'h4de3;
        culled_expected = 16'd0;
        clk             = 1'b0;
        rstn            = 1'b0;
        in_data         = '0;
        in_meta         = '0;
        in_valid        = 1'b0;
        out_ready       = 1'b1;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        test_reset_state();
        test_single_visible();
        test_z_clamp();
        test_right_cull();
        test_random_stream();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+testbench
design/fixed_pkg.sv
design/geometry_pkg.sv
design/triangle_stream_if.sv
design/triangle_intake.sv
design/reciprocal_divider.sv
design/triangle_projection.sv
design/viewport_cull.sv
design/raster_front_top.sv
testbench/raster_front_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module raster_front_tb -f build.f \
    -o raster_front_sim || exit 1
sim_output=$(./obj_dir/raster_front_sim)
echo "$sim_output"
echo "$sim_output" | grep -q "RESULT: PASS" && exit 0 || exit 1
